/* verilog/rv32_core_pkg.sv */
// rv32 core package
// shared types, major opcodes, pipeline status structs and trap cause codes
// for the two-stage RV32I-subset core.
package rv32_core_pkg;

  typedef logic [31:0] word_t;      // data or address word.
  typedef logic [4:0]  reg_idx_t;   // architectural register index.

  typedef enum logic [6:0] {
    OP_LOAD   = 7'h03,
    OP_IMM    = 7'h13,
    OP_STORE  = 7'h23,
    OP_REG    = 7'h33,
    OP_LUI    = 7'h37,
    OP_BRANCH = 7'h63,
    OP_JAL    = 7'h6f,
    OP_SYSTEM = 7'h73
  } opcode_e;

  typedef enum logic [1:0] {
    WB_ALU,                         // alu result.
    WB_MEM,                         // load data.
    WB_PC4,                         // link address.
    WB_IMM                          // upper immediate.
  } wb_src_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [31:0] {
    CAUSE_ILLEGAL          = 32'd2,
    CAUSE_BREAKPOINT       = 32'd3,
    CAUSE_LOAD_MISALIGNED  = 32'd4,
    CAUSE_STORE_MISALIGNED = 32'd6,
    CAUSE_ECALL_M          = 32'd11,
    CAUSE_M_EXT_IRQ        = 32'h8000_000b  // bit 31 marks an interrupt.
  } cause_e;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;                  // sign-extended immediate.
    alu_op_e  alu_op;
    logic     alu_src_imm;          // operand b from imm, not rs2.
    wb_src_e  wb_src;
    logic     reg_write;
    logic     dren;
    logic     dwen;
    logic     branch;
    logic     branch_ne;            // bne rather than beq.
    logic     jump;
    logic     illegal_insn;
    logic     breakpoint;
    logic     env_m;
    logic     ret;
  } ctrl_t;

  typedef struct packed {
    logic iren, i_ram_busy, dren, dwen, d_ram_busy;
    logic jump, branch, mispredict, halt;
    logic illegal_insn, fault_l, mal_l, fault_s, mal_s, breakpoint, env_m, ret;
    logic fault_insn, mal_insn, token_ex;
  } hazard_in_t;

  typedef struct packed {
    logic  pc_en;
    logic  npc_sel;
    logic  if_ex_flush;
    logic  if_ex_stall;
    logic  insert_priv_pc;
    word_t priv_pc;
  } hazard_out_t;

  typedef struct packed {
    logic  fault_insn, mal_insn, illegal_insn, fault_l, mal_l, fault_s, mal_s;
    logic  breakpoint, env_m, ret, intr;
    word_t epc;
    word_t badaddr;
  } trap_req_t;

  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    value;                // zero when nothing was written.
    logic     wrote;
    logic     trapped;
  } retire_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  ren;
    logic  wen;
  } dmem_req_t;

endpackage

/* verilog/fetch_stage.sv */
// fetch stage
// owns the pc, issues instruction reads and fills the fetch-to-execute
// pipeline register, honouring stall and flush from the hazard unit.
module fetch_stage #(
  parameter rv32_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic                       CLK,
  input  logic                       reset,
  input  rv32_core_pkg::hazard_out_t hz,
  input  rv32_core_pkg::word_t       branch_target,
  input  rv32_core_pkg::word_t       imem_rdata,
  input  logic                       i_ram_busy,
  output logic                       iren,
  output rv32_core_pkg::word_t       imem_addr,
  output rv32_core_pkg::word_t       ex_insn,
  output rv32_core_pkg::word_t       ex_pc,
  output logic                       ex_valid
);
  import rv32_core_pkg::*;

  word_t pc;                        // address being fetched.
  word_t next_pc;

  // trap entry and mret win over a taken branch.
  assign next_pc = hz.insert_priv_pc ? hz.priv_pc :
                   hz.npc_sel        ? branch_target :
                                       pc + 32'd4;

  assign imem_addr = pc;

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc   <= RESET_PC;
      iren <= 1'b1;                 // fetch runs nonstop once out of reset.
    end else if (hz.pc_en) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (hz.if_ex_flush) begin
      ex_valid <= 1'b0;             // bubble.
    end else if (!hz.if_ex_stall) begin
      ex_valid <= iren & ~i_ram_busy;  // no word yet, so a bubble.
    end
  end

  always_ff @(posedge CLK) begin
    if (!hz.if_ex_stall) begin
      ex_insn <= imem_rdata;
      ex_pc   <= pc;
    end
  end

endmodule

/* verilog/insn_decode.sv */
// instruction decoder
// combinational decode of the supported RV32I subset into control fields,
// immediates and exception flags.
module insn_decode (
  input  rv32_core_pkg::word_t insn,
  input  logic                 valid,
  output rv32_core_pkg::ctrl_t ctrl
);
  import rv32_core_pkg::*;

  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0] funct3;

  assign funct3 = insn[14:12];
  assign imm_i  = {{20{insn[31]}}, insn[31:20]};
  assign imm_s  = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b  = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u  = {insn[31:12], 12'd0};
  assign imm_j  = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    ctrl     = '0;                  // a bubble decodes to a no-op.
    ctrl.rs1 = insn[19:15];
    ctrl.rs2 = insn[24:20];
    ctrl.rd  = insn[11:7];
    if (valid) begin
      case (insn[6:0])
        OP_REG: begin
          ctrl.reg_write = 1'b1;
          case ({insn[31:25], funct3})
            10'b0000000_000: ctrl.alu_op = ALU_ADD;
            10'b0100000_000: ctrl.alu_op = ALU_SUB;
            10'b0000000_111: ctrl.alu_op = ALU_AND;
            10'b0000000_110: ctrl.alu_op = ALU_OR;
            default:         ctrl.illegal_insn = 1'b1;
          endcase
        end
        OP_IMM: begin
          ctrl.imm          = imm_i;
          ctrl.alu_src_imm  = 1'b1;
          ctrl.reg_write    = 1'b1;
          ctrl.illegal_insn = (funct3 != 3'b000);  // addi only.
        end
        OP_LUI: begin
          ctrl.imm         = imm_u;
          ctrl.alu_op      = ALU_PASS_B;
          ctrl.alu_src_imm = 1'b1;
          ctrl.wb_src      = WB_IMM;
          ctrl.reg_write   = 1'b1;
        end
        OP_LOAD: begin
          ctrl.imm          = imm_i;
          ctrl.alu_src_imm  = 1'b1;
          ctrl.wb_src       = WB_MEM;
          ctrl.reg_write    = 1'b1;
          ctrl.dren         = (funct3 == 3'b010);  // word loads only.
          ctrl.illegal_insn = (funct3 != 3'b010);
        end
        OP_STORE: begin
          ctrl.imm          = imm_s;
          ctrl.alu_src_imm  = 1'b1;
          ctrl.dwen         = (funct3 == 3'b010);
          ctrl.illegal_insn = (funct3 != 3'b010);
        end
        OP_BRANCH: begin
          ctrl.imm          = imm_b;
          ctrl.branch       = (funct3[2:1] == 2'b00);  // beq and bne.
          ctrl.branch_ne    = funct3[0];
          ctrl.illegal_insn = (funct3[2:1] != 2'b00);
        end
        OP_JAL: begin
          ctrl.imm       = imm_j;
          ctrl.jump      = 1'b1;
          ctrl.wb_src    = WB_PC4;
          ctrl.reg_write = 1'b1;
        end
        OP_SYSTEM: begin
          case (insn)
            32'h0000_0073: ctrl.env_m        = 1'b1;  // ecall.
            32'h0010_0073: ctrl.breakpoint   = 1'b1;  // ebreak.
            32'h3020_0073: ctrl.ret          = 1'b1;  // mret.
            default:       ctrl.illegal_insn = 1'b1;
          endcase
        end
        default: ctrl.illegal_insn = 1'b1;
      endcase
    end
  end

endmodule

/* verilog/execute_unit.sv */
// execute unit
// alu, branch compare, branch and jump target, and the data-memory request
// with a word alignment check.
module execute_unit (
  input  rv32_core_pkg::ctrl_t     ctrl,
  input  rv32_core_pkg::word_t     pc,
  input  rv32_core_pkg::word_t     rs1_val,
  input  rv32_core_pkg::word_t     rs2_val,
  output rv32_core_pkg::word_t     alu_result,
  output logic                     branch_taken,
  output rv32_core_pkg::word_t     target,
  output rv32_core_pkg::dmem_req_t dmem_req,
  output logic                     mal_l,
  output logic                     mal_s
);
  import rv32_core_pkg::*;

  word_t op_b;
  logic  rs_equal;
  logic  misaligned;

  assign op_b = ctrl.alu_src_imm ? ctrl.imm : rs2_val;

  always_comb begin
    case (ctrl.alu_op)
      ALU_SUB:    alu_result = rs1_val - op_b;
      ALU_AND:    alu_result = rs1_val & op_b;
      ALU_OR:     alu_result = rs1_val | op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = rs1_val + op_b;  // add, also load/store address.
    endcase
  end

  // no prediction, so every taken branch redirects fetch.
  assign rs_equal     = (rs1_val == rs2_val);
  assign branch_taken = ctrl.jump | (ctrl.branch & (ctrl.branch_ne ^ rs_equal));
  assign target       = pc + ctrl.imm;

  assign misaligned = (alu_result[1:0] != 2'b00);
  assign mal_l      = ctrl.dren & misaligned;
  assign mal_s      = ctrl.dwen & misaligned;

  // a misaligned access never reaches memory.
  assign dmem_req.addr  = alu_result;
  assign dmem_req.wdata = rs2_val;
  assign dmem_req.ren   = ctrl.dren & ~misaligned;
  assign dmem_req.wen   = ctrl.dwen & ~misaligned;

endmodule

/* verilog/result_writeback.sv */
// result writeback
// register file with x0 hardwired to zero, writeback source select and the
// registered retire record.
module result_writeback (
  input  logic                   CLK,
  input  logic                   reset,
  input  rv32_core_pkg::ctrl_t   ctrl,
  input  rv32_core_pkg::word_t   pc,
  input  rv32_core_pkg::word_t   alu_result,
  input  rv32_core_pkg::word_t   dmem_rdata,
  input  logic                   complete,
  input  logic                   trapped,
  output rv32_core_pkg::word_t   rs1_val,
  output rv32_core_pkg::word_t   rs2_val,
  output logic                   retire_valid,
  output rv32_core_pkg::retire_t retire
);
  import rv32_core_pkg::*;

  word_t regs [1:31];               // x1 to x31.
  word_t wb_data;
  logic  wen;

  assign rs1_val = (ctrl.rs1 == 5'd0) ? 32'd0 : regs[ctrl.rs1];
  assign rs2_val = (ctrl.rs2 == 5'd0) ? 32'd0 : regs[ctrl.rs2];

  always_comb begin
    case (ctrl.wb_src)
      WB_MEM:  wb_data = dmem_rdata;  // valid in the completing cycle only.
      WB_PC4:  wb_data = pc + 32'd4;
      WB_IMM:  wb_data = ctrl.imm;
      default: wb_data = alu_result;
    endcase
  end

  // a trapping instruction retires without touching the register file.
  assign wen = complete & ~trapped & ctrl.reg_write & (ctrl.rd != 5'd0);

  always_ff @(posedge CLK) begin
    if (wen) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else begin
      retire_valid <= complete;     // one strobe per finished instruction.
    end
  end

  always_ff @(posedge CLK) begin
    if (complete) begin
      retire.pc      <= pc;
      retire.rd      <= ctrl.rd;
      retire.value   <= wen ? wb_data : 32'd0;
      retire.wrote   <= wen;
      retire.trapped <= trapped;
    end
  end

endmodule

/* verilog/hazard_unit.sv */
// hazard unit
// drives pc enable, next-pc select and the flush and stall of the
// fetch-to-execute register, and forwards exceptions to the trap unit.
module hazard_unit (
  input  rv32_core_pkg::hazard_in_t  hin,
  input  logic                       insert_pc,
  input  rv32_core_pkg::word_t       priv_pc,
  input  logic                       pipe_clear,
  input  logic                       intr_pending,
  input  rv32_core_pkg::word_t       epc_f,
  input  rv32_core_pkg::word_t       epc_e,
  input  rv32_core_pkg::word_t       badaddr_f,
  input  rv32_core_pkg::word_t       badaddr_e,
  output rv32_core_pkg::hazard_out_t hout,
  output rv32_core_pkg::trap_req_t   treq
);

  logic dmem_access, branch_jump, wait_for_imem, wait_for_dmem;
  logic ex_flush_hazard, e_ex_stage, e_f_stage, intr;

  assign dmem_access   = hin.dren | hin.dwen;
  assign branch_jump   = hin.jump | (hin.branch & hin.mispredict);
  assign wait_for_imem = hin.iren & hin.i_ram_busy;
  assign wait_for_dmem = dmem_access & hin.d_ram_busy;

  assign e_ex_stage = hin.illegal_insn | hin.fault_l | hin.mal_l | hin.fault_s |
                      hin.mal_s | hin.breakpoint | hin.env_m;
  assign e_f_stage  = hin.fault_insn | hin.mal_insn;
  assign intr       = ~e_ex_stage & ~e_f_stage & intr_pending;  // exceptions go first.

  // pending interrupt drains execute and holds the pc. trap entry clears the pipe.
  assign ex_flush_hazard = ((intr | e_f_stage) & ~wait_for_dmem) | pipe_clear | hin.ret;

  assign hout.npc_sel     = branch_jump;
  assign hout.pc_en       = (~wait_for_dmem & ~wait_for_imem & ~hin.halt & ~ex_flush_hazard) |
                            branch_jump | insert_pc | hin.ret;
  assign hout.if_ex_flush = ex_flush_hazard | branch_jump |
                            (wait_for_imem & dmem_access & ~hin.d_ram_busy);
  assign hout.if_ex_stall = (wait_for_dmem | (wait_for_imem & ~dmem_access) | hin.halt) &
                            (~ex_flush_hazard | e_ex_stage);
  assign hout.insert_priv_pc = insert_pc;
  assign hout.priv_pc        = priv_pc;

  assign treq.fault_insn   = hin.fault_insn;
  assign treq.mal_insn     = hin.mal_insn;
  assign treq.illegal_insn = hin.illegal_insn;
  assign treq.fault_l      = hin.fault_l;
  assign treq.mal_l        = hin.mal_l;
  assign treq.fault_s      = hin.fault_s;
  assign treq.mal_s        = hin.mal_s;
  assign treq.breakpoint   = hin.breakpoint;
  assign treq.env_m        = hin.env_m;
  assign treq.ret          = hin.ret;
  assign treq.intr         = intr;
  assign treq.epc          = e_f_stage ? epc_f : epc_e;
  assign treq.badaddr      = e_f_stage ? badaddr_f : badaddr_e;

endmodule

/* verilog/trap_unit.sv */
// trap unit
// holds mepc and mcause, picks the trap vector or the mret return address,
// and masks the external interrupt while a handler runs.
module trap_unit #(
  parameter rv32_core_pkg::word_t TRAP_VECTOR = 32'h0000_0100
) (
  input  logic                    CLK,
  input  logic                    reset,
  input  rv32_core_pkg::trap_req_t treq,
  input  logic                    token_ex,
  input  logic                    ext_irq,
  output logic                    insert_pc,
  output rv32_core_pkg::word_t    priv_pc,
  output logic                    pipe_clear,
  output logic                    intr_pending
);
  import rv32_core_pkg::*;

  word_t  mepc;
  cause_e mcause;
  cause_e cause;
  logic   exception, take_irq, irq_mask;

  assign exception = treq.illegal_insn | treq.breakpoint | treq.env_m |
                     treq.mal_l | treq.mal_s;
  assign take_irq  = treq.intr & ~token_ex;  // only with execute empty.

  assign pipe_clear   = exception | take_irq;
  assign insert_pc    = pipe_clear | treq.ret;
  assign intr_pending = ext_irq & ~irq_mask;

  // an exception returns past the trapping instruction, an interrupt
  // returns to the instruction it displaced.
  always_comb begin
    if (!treq.ret) begin
      priv_pc = TRAP_VECTOR;
    end else if (mcause[31]) begin
      priv_pc = mepc;
    end else begin
      priv_pc = mepc + 32'd4;
    end
  end

  always_comb begin
    if (treq.illegal_insn)    cause = CAUSE_ILLEGAL;
    else if (treq.breakpoint) cause = CAUSE_BREAKPOINT;
    else if (treq.env_m)      cause = CAUSE_ECALL_M;
    else if (treq.mal_l)      cause = CAUSE_LOAD_MISALIGNED;
    else if (treq.mal_s)      cause = CAUSE_STORE_MISALIGNED;
    else                      cause = CAUSE_M_EXT_IRQ;
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      irq_mask <= 1'b0;
    end else if (pipe_clear) begin
      irq_mask <= 1'b1;             // handler entered.
    end else if (treq.ret) begin
      irq_mask <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (pipe_clear) begin
      mepc   <= treq.epc;
      mcause <= cause;
    end
  end

endmodule

/* verilog/two_stage_core.sv */
// two-stage core
// fetch, then a single execute stage doing decode, execute and writeback,
// with the hazard unit and trap unit steering the pc and the pipe.
module two_stage_core #(
  parameter rv32_core_pkg::word_t RESET_PC    = 32'h0000_0000,
  parameter rv32_core_pkg::word_t TRAP_VECTOR = 32'h0000_0100
) (
  input  logic                     CLK,
  input  logic                     reset,
  input  rv32_core_pkg::word_t     imem_rdata,
  input  logic                     i_ram_busy,
  input  rv32_core_pkg::word_t     dmem_rdata,
  input  logic                     d_ram_busy,
  input  logic                     ext_irq,
  output logic                     iren,
  output rv32_core_pkg::word_t     imem_addr,
  output rv32_core_pkg::dmem_req_t dmem_req,
  output logic                     retire_valid,
  output rv32_core_pkg::retire_t   retire
);
  import rv32_core_pkg::*;

  ctrl_t       ctrl;
  hazard_in_t  hin;
  hazard_out_t hout;
  trap_req_t   treq;
  word_t       ex_insn, ex_pc, rs1_val, rs2_val, alu_result, target, epc_e, priv_pc;
  logic        ex_valid, branch_taken, mal_l, mal_s, complete, trapped;
  logic        insert_pc, pipe_clear, intr_pending;

  fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
    .CLK, .reset, .hz(hout), .branch_target(target), .imem_rdata, .i_ram_busy,
    .iren, .imem_addr, .ex_insn, .ex_pc, .ex_valid
  );

  insn_decode u_decode (.insn(ex_insn), .valid(ex_valid), .ctrl);

  execute_unit u_execute (
    .ctrl, .pc(ex_pc), .rs1_val, .rs2_val, .alu_result, .branch_taken, .target,
    .dmem_req, .mal_l, .mal_s
  );

  // execute finishes unless held, and a flush always lets it go.
  assign complete = ex_valid & (hout.if_ex_flush | ~hout.if_ex_stall);
  assign trapped  = ctrl.illegal_insn | ctrl.breakpoint | ctrl.env_m | mal_l | mal_s;

  result_writeback u_writeback (
    .CLK, .reset, .ctrl, .pc(ex_pc), .alu_result, .dmem_rdata, .complete, .trapped,
    .rs1_val, .rs2_val, .retire_valid, .retire
  );

  assign hin = '{
    iren: iren, i_ram_busy: i_ram_busy,
    dren: dmem_req.ren, dwen: dmem_req.wen, d_ram_busy: d_ram_busy,
    jump: ctrl.jump, branch: ctrl.branch, mispredict: branch_taken,
    halt: 1'b0,
    illegal_insn: ctrl.illegal_insn, fault_l: 1'b0, mal_l: mal_l,
    fault_s: 1'b0, mal_s: mal_s, breakpoint: ctrl.breakpoint,
    env_m: ctrl.env_m, ret: ctrl.ret,
    fault_insn: 1'b0, mal_insn: 1'b0,  // no fetch-side faults.
    token_ex: ex_valid
  };

  // with execute empty, the pending fetch pc is the one not executed.
  assign epc_e = ex_valid ? ex_pc : imem_addr;

  hazard_unit u_hazard (
    .hin, .insert_pc, .priv_pc, .pipe_clear, .intr_pending,
    .epc_f(imem_addr), .epc_e, .badaddr_f(imem_addr), .badaddr_e(alu_result),
    .hout, .treq
  );

  trap_unit #(.TRAP_VECTOR(TRAP_VECTOR)) u_trap (
    .CLK, .reset, .treq, .token_ex(ex_valid), .ext_irq,
    .insert_pc, .priv_pc, .pipe_clear, .intr_pending
  );

endmodule

/* tb/tb_two_stage_core.sv */
// testbench for the two-stage core
// models instruction and data memory with random busy levels, loads program,
// data and expected results from the stimulus file, and checks every retire
// and every store, plus one external interrupt taken mid-stream.
module tb_two_stage_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv32_core_pkg::*;

  localparam word_t RESET_PC    = 32'h0000_0000;
  localparam word_t TRAP_VECTOR = 32'h0000_0100;
  localparam int    MAX_CYCLES  = 3000;           // run limit after reset.

  logic      CLK;
  logic      reset;
  word_t     imem_rdata, dmem_rdata;
  logic      i_ram_busy, d_ram_busy, ext_irq;
  logic      iren;
  word_t     imem_addr;
  dmem_req_t dmem_req;
  logic      retire_valid;
  retire_t   retire;

  word_t       imem [0:127];                     // 512 bytes of program space.
  word_t       dmem [0:255];                     // 1 KiB of data space.
  retire_t     exp_retire [$];
  dmem_req_t   exp_store [$];
  retire_t     irq_retire;                       // handler retire seen during the irq.
  word_t       irq_after_pc;                     // raise ext_irq once this pc retires.
  logic        irq_armed, irq_taken;
  logic [31:0] rng_state;
  int          pass_count, fail_count;

  two_stage_core #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VECTOR)) uut (
    .CLK, .reset, .imem_rdata, .i_ram_busy, .dmem_rdata, .d_ram_busy, .ext_irq,
    .iren, .imem_addr, .dmem_req, .retire_valid, .retire
  );

  always #5 CLK = ~CLK;

  // both memories answer in the same cycle as the request.
  assign imem_rdata = iren ? imem[imem_addr[8:2]] : 32'd0;
  assign dmem_rdata = dmem_req.ren ? dmem[dmem_req.addr[9:2]] : 32'd0;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_retire(input string name, input retire_t exp, input retire_t got);
    logic ok;
    ok = (exp.pc == got.pc) && (exp.value == got.value) && (exp.wrote == got.wrote) &&
         (exp.trapped == got.trapped) && (!exp.wrote || exp.rd == got.rd);  // rd only if written.
    if (ok) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("CHECK FAILED %s: expected pc %h rd %0d value %h wrote %b trapped %b, %s",
               name, exp.pc, exp.rd, exp.value, exp.wrote, exp.trapped,
               $sformatf("actual pc %h rd %0d value %h wrote %b trapped %b",
                         got.pc, got.rd, got.value, got.wrote, got.trapped));
    end
  endtask

  task automatic check_store(input dmem_req_t got);
    dmem_req_t exp;
    if (exp_store.size() == 0) begin
      fail_count++;
      $display("store to %h with data %h was not expected", got.addr, got.wdata);
    end else begin
      exp = exp_store.pop_front();
      if (exp.addr == got.addr && exp.wdata == got.wdata && exp.ren == got.ren) begin
        pass_count++;
        $display("PASS store %h", got.addr);
      end else begin
        fail_count++;
        $display("CHECK FAILED store: expected addr %h data %h ren %b, %s",
                 exp.addr, exp.wdata, exp.ren,
                 $sformatf("actual addr %h data %h ren %b", got.addr, got.wdata, got.ren));
      end
    end
  endtask

  task automatic handle_retire(input retire_t got);
    retire_t exp;
    if (irq_armed && !irq_taken && got.pc == TRAP_VECTOR) begin
      check_retire("interrupt handler", irq_retire, got);  // may land anywhere in the window.
      irq_taken = 1'b1;
    end else if (exp_retire.size() > 0) begin
      exp = exp_retire.pop_front();
      check_retire($sformatf("retire pc %h", exp.pc), exp, got);
      if (got.pc == irq_after_pc && !irq_armed) begin
        ext_irq   <= 1'b1;
        irq_armed = 1'b1;
      end
    end
  endtask

  // busy levels, retire monitor, store monitor and irq release.
  always @(posedge CLK) begin
    if (reset) begin
      i_ram_busy <= 1'b0;
      d_ram_busy <= 1'b0;
    end else begin
      rng_state = xorshift(rng_state);
      i_ram_busy <= (rng_state % 32'd3 == 32'd0);  // busy about a third of the time.
      rng_state = xorshift(rng_state);
      d_ram_busy <= (rng_state % 32'd3 == 32'd0);
      if (retire_valid) begin
        handle_retire(retire);
      end
      if (dmem_req.wen && !d_ram_busy) begin
        dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        check_store(dmem_req);
      end
      if (ext_irq && imem_addr == TRAP_VECTOR) begin
        ext_irq <= 1'b0;                         // level drops once the handler is fetched.
      end
    end
  end

  task automatic load_stimulus();
    integer      fd, code, k;
    logic [7:0]  tag;
    logic [31:0] a, w0, w1, w2, w3;
    string       line;
    retire_t     r;
    dmem_req_t   s;
    fd = $fopen("tb/core_stimulus.txt", "r");
    if (fd == 0) begin
      fail_count++;
      $display("could not open the stimulus file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1) break;
      case (tag)
        "#": code = $fgets(line, fd);            // comment line.
        "I": begin
          code = $fscanf(fd, "%h %h %h %h %h", a, w0, w1, w2, w3);
          k = int'(a[8:2]);
          imem[k]     = w0;
          imem[k + 1] = w1;
          imem[k + 2] = w2;
          imem[k + 3] = w3;
        end
        "D": begin
          code = $fscanf(fd, "%h %h", a, w0);
          dmem[a[9:2]] = w0;
        end
        "S": begin
          code = $fscanf(fd, "%h %h", a, w0);
          s = '{addr: a, wdata: w0, ren: 1'b0, wen: 1'b1};
          exp_store.push_back(s);
        end
        "R", "H": begin
          code = $fscanf(fd, "%h %h %h %h %h", a, w0, w1, w2, w3);
          r = '{pc: a, rd: w0[4:0], value: w1, wrote: w2[0], trapped: w3[0]};
          if (tag == "R") exp_retire.push_back(r);
          else irq_retire = r;
        end
        "Q": code = $fscanf(fd, "%h", irq_after_pc);
        default: begin
          fail_count++;
          $display("unknown line tag in the stimulus file");
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    int cycles;
    CLK          = 1'b0;
    reset        <= 1'b1;
    i_ram_busy   <= 1'b0;
    d_ram_busy   <= 1'b0;
    ext_irq      <= 1'b0;
    rng_state    = 32'h702bf842;
    irq_armed    = 1'b0;
    irq_taken    = 1'b0;
    irq_after_pc = 32'hffff_ffff;
    pass_count   = 0;
    fail_count   = 0;
    for (int i = 0; i < 128; i++) imem[i] = 32'd0;  // zero decodes as illegal.
    for (int i = 0; i < 256; i++) dmem[i] = (i * 4) ^ 32'h5a5a_0f0f;
    load_stimulus();
    repeat (10) @(posedge CLK);
    reset <= 1'b0;
    cycles = 0;
    while ((exp_retire.size() > 0 || exp_store.size() > 0) && cycles < MAX_CYCLES) begin
      @(posedge CLK);
      cycles++;
    end
    if (exp_retire.size() > 0 || exp_store.size() > 0) begin
      fail_count++;
      $display("timeout: %0d retires and %0d stores never arrived",
               exp_retire.size(), exp_store.size());
    end
    if (!irq_taken) begin
      fail_count++;
      $display("the interrupt handler never retired");
    end
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* tb/core_stimulus.txt */
# I addr w0 w1 w2 w3 = four program words, D addr word = data, S addr data = store
# R/H pc rd value wrote trapped = retire (H is the irq handler), Q pc = irq after pc
I 00000000 00500093 00c00113 002081b3 40110233
I 00000010 0041f2b3 0041e333 123453b7 04000413
I 00000020 00042483 00742223 00442503 00a485b3
I 00000030 00108663 00100613 00200613 00209463
I 00000040 00300613 00208463 00c006ef 00400613
I 00000050 00500613 00000000 00000073 00100073
I 00000060 00242703 00100793 00178793 00178793
I 00000070 00178793 00178793 0000006f 00000000
I 00000100 30200073 00000000 00000000 00000000
D 00000040 00000100
D 00000044 deadbeef
S 00000044 12345000
Q 00000064
H 00000100 00 00000000 0 0
R 00000000 01 00000005 1 0
R 00000004 02 0000000c 1 0
R 00000008 03 00000011 1 0
R 0000000c 04 00000007 1 0
R 00000010 05 00000001 1 0
R 00000014 06 00000017 1 0
R 00000018 07 12345000 1 0
R 0000001c 08 00000040 1 0
R 00000020 09 00000100 1 0
R 00000024 04 00000000 0 0
R 00000028 0a 12345000 1 0
R 0000002c 0b 12345100 1 0
R 00000030 0c 00000000 0 0
R 0000003c 08 00000000 0 0
R 00000044 08 00000000 0 0
R 00000048 0d 0000004c 1 0
R 00000054 00 00000000 0 1
R 00000100 00 00000000 0 0
R 00000058 00 00000000 0 1
R 00000100 00 00000000 0 0
R 0000005c 00 00000000 0 1
R 00000100 00 00000000 0 0
R 00000060 0e 00000000 0 1
R 00000100 00 00000000 0 0
R 00000064 0f 00000001 1 0
R 00000068 0f 00000002 1 0
R 0000006c 0f 00000003 1 0
R 00000070 0f 00000004 1 0
R 00000074 0f 00000005 1 0
R 00000078 00 00000000 0 0

/* src.f */
verilog/rv32_core_pkg.sv
verilog/fetch_stage.sv
verilog/insn_decode.sv
verilog/execute_unit.sv
verilog/result_writeback.sv
verilog/hazard_unit.sv
verilog/trap_unit.sv
verilog/two_stage_core.sv
tb/tb_two_stage_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the core testbench with Verilator, then judge the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps --top-module tb_two_stage_core \
  -f src.f -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { echo "build or simulation did not complete"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0
